//--- rtl/router_pkg.sv
package router_pkg;

  localparam int NUM_PORTS = 3;

  typedef logic [7:0] byte_t;
  typedef logic [1:0] port_sel_t;
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  localparam port_sel_t INVALID_PORT = 2'd3;

  // Header byte layout.
  localparam int HDR_PORT_LSB = 0;
  localparam int HDR_PORT_MSB = 1;
  localparam int HDR_LEN_LSB = 2;
  localparam int HDR_LEN_MSB = 7;

  typedef enum logic [3:0] {
    decode_address,
    load_first_data,
    load_data,
    fifo_full_state,
    load_after_full,
    load_parity,
    check_parity_error,
    wait_till_empty,
    drop_packet
  } route_state_t;

endpackage

//--- rtl/router_fsm.sv
`timescale 1ns/1ns

module router_fsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pkt_valid,
  input  router_pkg::port_sel_t data_port,
  input  logic                  fifo_full,
  input  router_pkg::port_vec_t fifo_empty,
  input  router_pkg::port_vec_t soft_reset,
  input  logic                  parity_done,
  input  logic                  low_pkt_valid,
  output logic                  write_enb_reg,
  output logic                  detect_addr,
  output logic                  lfd_state,
  output logic                  ld_state,
  output logic                  laf_state,
  output logic                  full_state,
  output logic                  rst_int_reg,
  output logic                  busy
);

  router_pkg::route_state_t state;
  router_pkg::route_state_t state_nxt;
  router_pkg::port_sel_t    port_q;
  logic                     port_flushed;

  // Port of the packet in flight, kept for the empty check and the flush.
  always_ff @(posedge clk) begin
    if (!rst) begin
      port_q <= '0;
    end else if (state == router_pkg::decode_address && pkt_valid) begin
      port_q <= data_port;
    end
  end

  assign port_flushed = (port_q != router_pkg::INVALID_PORT) && soft_reset[port_q];

  always_comb begin
    state_nxt = state;
    case (state)
      router_pkg::decode_address: begin
        if (pkt_valid) begin
          if (data_port == router_pkg::INVALID_PORT) begin
            state_nxt = router_pkg::drop_packet;
          end else if (fifo_empty[data_port]) begin
            state_nxt = router_pkg::load_first_data;
          end else begin
            state_nxt = router_pkg::wait_till_empty;
          end
        end
      end
      router_pkg::drop_packet: begin
        if (!pkt_valid) state_nxt = router_pkg::decode_address;
      end
      router_pkg::wait_till_empty: begin
        if (fifo_empty[port_q]) state_nxt = router_pkg::load_first_data;
      end
      router_pkg::load_first_data: state_nxt = router_pkg::load_data;
      router_pkg::load_data: begin
        if (fifo_full) begin
          state_nxt = router_pkg::fifo_full_state;
        end else if (!pkt_valid) begin
          state_nxt = router_pkg::load_parity;
        end
      end
      router_pkg::load_parity: begin
        state_nxt = fifo_full ? router_pkg::fifo_full_state : router_pkg::check_parity_error;
      end
      router_pkg::fifo_full_state: begin
        if (!fifo_full) state_nxt = router_pkg::load_after_full;
      end
      router_pkg::load_after_full: begin
        // Parity already in dout means this write was the last one.
        if (parity_done) begin
          state_nxt = router_pkg::check_parity_error;
        end else if (low_pkt_valid) begin
          state_nxt = router_pkg::load_parity;
        end else begin
          state_nxt = router_pkg::load_data;
        end
      end
      router_pkg::check_parity_error: state_nxt = router_pkg::decode_address;
      default: state_nxt = router_pkg::decode_address;
    endcase
    if (state != router_pkg::decode_address && state != router_pkg::drop_packet &&
        port_flushed) begin
      state_nxt = router_pkg::decode_address;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= router_pkg::decode_address;
    end else begin
      state <= state_nxt;
    end
  end

  assign detect_addr   = (state == router_pkg::decode_address);
  assign lfd_state     = (state == router_pkg::load_first_data);
  assign ld_state      = (state == router_pkg::load_data);
  assign laf_state     = (state == router_pkg::load_after_full);
  assign full_state    = (state == router_pkg::fifo_full_state);
  assign rst_int_reg   = (state == router_pkg::check_parity_error);
  assign write_enb_reg = ld_state || laf_state || (state == router_pkg::load_parity);

  assign busy = lfd_state || full_state || laf_state || rst_int_reg ||
                (state == router_pkg::load_parity) ||
                (state == router_pkg::wait_till_empty);

endmodule

//--- rtl/router_reg.sv
`timescale 1ns/1ns

module router_reg (
  input  logic               clk,
  input  logic               rst,
  input  logic               pkt_valid,
  input  router_pkg::byte_t  data_in,
  input  logic               fifo_full,
  input  logic               detect_addr,
  input  logic               ld_state,
  input  logic               laf_state,
  input  logic               full_state,
  input  logic               lfd_state,
  input  logic               rst_int_reg,
  output router_pkg::byte_t  dout,
  output logic               err,
  output logic               parity_done,
  output logic               low_pkt_valid
);

  router_pkg::byte_t header;
  router_pkg::byte_t int_reg;
  router_pkg::byte_t int_parity;
  router_pkg::byte_t ext_parity;

  // Parity byte has been taken from the input.
  always_ff @(posedge clk) begin
    if (!rst) begin
      low_pkt_valid <= 1'b0;
    end else if (rst_int_reg || detect_addr) begin
      low_pkt_valid <= 1'b0;
    end else if (ld_state && !pkt_valid) begin
      low_pkt_valid <= 1'b1;
    end
  end

  // Parity byte sits in dout, waiting for its write.
  always_ff @(posedge clk) begin
    if (!rst) begin
      parity_done <= 1'b0;
    end else if (detect_addr) begin
      parity_done <= 1'b0;
    end else if ((ld_state && !fifo_full && !pkt_valid) ||
                 (laf_state && low_pkt_valid && !parity_done)) begin
      parity_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (detect_addr && pkt_valid) header <= data_in;
    if (ld_state && fifo_full) int_reg <= data_in;
  end

  // A byte taken against a full FIFO waits in int_reg.
  always_ff @(posedge clk) begin
    if (lfd_state) begin
      dout <= header;
    end else if (ld_state && !fifo_full) begin
      dout <= data_in;
    end else if (laf_state && !parity_done) begin
      dout <= int_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (detect_addr) begin
      int_parity <= '0;
    end else if (lfd_state) begin
      int_parity <= header;
    end else if (ld_state && pkt_valid) begin
      int_parity <= int_parity ^ data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_state && !pkt_valid) ext_parity <= data_in;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      err <= 1'b0;
    end else if (detect_addr && pkt_valid) begin
      err <= 1'b0;
    end else if (parity_done && !full_state) begin
      err <= (int_parity != ext_parity);
    end
  end

endmodule

//--- rtl/router_sync.sv
`timescale 1ns/1ns

module router_sync #(
  parameter int SOFT_RESET_CYCLES = 30
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  detect_addr,
  input  router_pkg::port_sel_t data_port,
  input  logic                  write_enb_reg,
  input  router_pkg::port_vec_t read_enb,
  input  router_pkg::port_vec_t full,
  input  router_pkg::port_vec_t empty,
  output router_pkg::port_vec_t write_enb,
  output logic                  fifo_full,
  output router_pkg::port_vec_t vld_out,
  output router_pkg::port_vec_t soft_reset
);

  localparam int CW = $clog2(SOFT_RESET_CYCLES + 1);

  router_pkg::port_sel_t port_q;
  logic [CW-1:0]         timer [router_pkg::NUM_PORTS];

  always_ff @(posedge clk) begin
    if (!rst) begin
      port_q <= '0;
    end else if (detect_addr) begin
      port_q <= data_port;
    end
  end

  always_comb begin
    write_enb = '0;
    fifo_full = 1'b0;
    if (port_q != router_pkg::INVALID_PORT) begin
      write_enb[port_q] = write_enb_reg;
      fifo_full = full[port_q];
    end
  end

  assign vld_out = ~empty;

  // Idle timers, one per port.
  always_ff @(posedge clk) begin
    if (!rst) begin
      soft_reset <= '0;
      for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
        timer[i] <= '0;
      end
    end else begin
      for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
        if (vld_out[i] && !read_enb[i]) begin
          if (timer[i] == CW'(SOFT_RESET_CYCLES - 1)) begin
            soft_reset[i] <= 1'b1;
            timer[i] <= '0;
          end else begin
            soft_reset[i] <= 1'b0;
            timer[i] <= timer[i] + 1'b1;
          end
        end else begin
          soft_reset[i] <= 1'b0;
          timer[i] <= '0;
        end
      end
    end
  end

endmodule

//--- rtl/router_fifo.sv
`timescale 1ns/1ns

module router_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              soft_reset,
  input  logic              write_enb,
  input  logic              read_enb,
  input  router_pkg::byte_t data_in,
  output router_pkg::byte_t data_out,
  output logic              full,
  output logic              empty
);

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNTW = $clog2(FIFO_DEPTH + 1);

  router_pkg::byte_t mem [FIFO_DEPTH];
  logic [PW-1:0]     wr_ptr;
  logic [PW-1:0]     rd_ptr;
  logic [CNTW-1:0]   count;
  logic              do_wr;
  logic              do_rd;

  assign full  = (count == CNTW'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign do_wr = write_enb && !full;
  assign do_rd = read_enb && !empty;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    next_ptr = (ptr == PW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= data_in;
  end

  always_ff @(posedge clk) begin
    if (!rst || soft_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= next_ptr(wr_ptr);
      if (do_rd) rd_ptr <= next_ptr(rd_ptr);
      // Simultaneous push and pop leave the count alone.
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // Popped byte shows one cycle after read_enb.
  always_ff @(posedge clk) begin
    if (!rst || soft_reset) begin
      data_out <= '0;
    end else if (do_rd) begin
      data_out <= mem[rd_ptr];
    end
  end

endmodule

//--- rtl/router_top.sv
`timescale 1ns/1ns

module router_top #(
  parameter int FIFO_DEPTH = 16,
  parameter int SOFT_RESET_CYCLES = 30
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pkt_valid,
  input  router_pkg::byte_t     data_in,
  input  router_pkg::port_vec_t read_enb,
  output router_pkg::byte_t     data_out_0,
  output router_pkg::byte_t     data_out_1,
  output router_pkg::byte_t     data_out_2,
  output router_pkg::port_vec_t vld_out,
  output logic                  err,
  output logic                  busy
);

  router_pkg::byte_t     dout;
  router_pkg::port_vec_t write_enb;
  router_pkg::port_vec_t full;
  router_pkg::port_vec_t empty;
  router_pkg::port_vec_t soft_reset;
  logic                  fifo_full;
  logic                  write_enb_reg;
  logic                  detect_addr;
  logic                  lfd_state;
  logic                  ld_state;
  logic                  laf_state;
  logic                  full_state;
  logic                  rst_int_reg;
  logic                  parity_done;
  logic                  low_pkt_valid;

  router_fsm fsm0 (
    .clk           (clk),
    .rst           (rst),
    .pkt_valid     (pkt_valid),
    .data_port     (data_in[router_pkg::HDR_PORT_MSB:router_pkg::HDR_PORT_LSB]),
    .fifo_full     (fifo_full),
    .fifo_empty    (empty),
    .soft_reset    (soft_reset),
    .parity_done   (parity_done),
    .low_pkt_valid (low_pkt_valid),
    .write_enb_reg (write_enb_reg),
    .detect_addr   (detect_addr),
    .lfd_state     (lfd_state),
    .ld_state      (ld_state),
    .laf_state     (laf_state),
    .full_state    (full_state),
    .rst_int_reg   (rst_int_reg),
    .busy          (busy)
  );

  router_reg reg0 (
    .clk           (clk),
    .rst           (rst),
    .pkt_valid     (pkt_valid),
    .data_in       (data_in),
    .fifo_full     (fifo_full),
    .detect_addr   (detect_addr),
    .ld_state      (ld_state),
    .laf_state     (laf_state),
    .full_state    (full_state),
    .lfd_state     (lfd_state),
    .rst_int_reg   (rst_int_reg),
    .dout          (dout),
    .err           (err),
    .parity_done   (parity_done),
    .low_pkt_valid (low_pkt_valid)
  );

  router_sync #(
    .SOFT_RESET_CYCLES (SOFT_RESET_CYCLES)
  ) sync0 (
    .clk           (clk),
    .rst           (rst),
    .detect_addr   (detect_addr),
    .data_port     (data_in[router_pkg::HDR_PORT_MSB:router_pkg::HDR_PORT_LSB]),
    .write_enb_reg (write_enb_reg),
    .read_enb      (read_enb),
    .full          (full),
    .empty         (empty),
    .write_enb     (write_enb),
    .fifo_full     (fifo_full),
    .vld_out       (vld_out),
    .soft_reset    (soft_reset)
  );

  router_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
    .clk(clk), .rst(rst), .soft_reset(soft_reset[0]), .write_enb(write_enb[0]),
    .read_enb(read_enb[0]), .data_in(dout), .data_out(data_out_0),
    .full(full[0]), .empty(empty[0])
  );

  router_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo1 (
    .clk(clk), .rst(rst), .soft_reset(soft_reset[1]), .write_enb(write_enb[1]),
    .read_enb(read_enb[1]), .data_in(dout), .data_out(data_out_1),
    .full(full[1]), .empty(empty[1])
  );

  router_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo2 (
    .clk(clk), .rst(rst), .soft_reset(soft_reset[2]), .write_enb(write_enb[2]),
    .read_enb(read_enb[2]), .data_in(dout), .data_out(data_out_2),
    .full(full[2]), .empty(empty[2])
  );

endmodule

//--- tests/router_properties.sv
`timescale 1ns/1ns

module router_properties (
  input logic                  clk,
  input logic                  rst,
  input logic                  pkt_valid,
  input router_pkg::byte_t     data_in,
  input logic                  detect_addr,
  input logic                  busy,
  input router_pkg::port_vec_t write_enb,
  input router_pkg::port_vec_t vld_out,
  input router_pkg::port_vec_t soft_reset
);

  // A header for a real port holds the source for at least one cycle.
  header_stalls: assert property (@(posedge clk) disable iff (!rst)
    detect_addr && pkt_valid &&
    data_in[router_pkg::HDR_PORT_MSB:router_pkg::HDR_PORT_LSB] != router_pkg::INVALID_PORT
    |=> busy)
    else $error("busy did not rise after a header for a valid port");

  // A port turns valid only after a write into its FIFO.
  valid_after_write: assert property (@(posedge clk) disable iff (!rst)
    (vld_out & ~$past(vld_out) & ~$past(write_enb)) == '0)
    else $error("vld_out rose without a write to that FIFO");

  flush_empties: assert property (@(posedge clk) disable iff (!rst)
    soft_reset != '0 |=> (vld_out & $past(soft_reset)) == '0)
    else $error("a soft reset left its FIFO holding data");

endmodule

bind router_top router_properties props0 (
  .clk         (clk),
  .rst         (rst),
  .pkt_valid   (pkt_valid),
  .data_in     (data_in),
  .detect_addr (detect_addr),
  .busy        (busy),
  .write_enb   (write_enb),
  .vld_out     (vld_out),
  .soft_reset  (soft_reset)
);

//--- tests/router_tb.sv
`timescale 1ns/1ns

module router_tb;

  localparam int FIFO_DEPTH = 16;
  localparam int SOFT_RESET_CYCLES = 30;
  localparam int NUM_PKTS = 15;
  localparam logic [31:0] SEED = 32'h8e98_da3e;

  logic                  clk;
  logic                  rst;
  logic                  pkt_valid;
  router_pkg::byte_t     data_in;
  router_pkg::port_vec_t read_enb;
  router_pkg::byte_t     data_out [router_pkg::NUM_PORTS];
  router_pkg::port_vec_t vld_out;
  logic                  err;
  logic                  busy;

  router_pkg::byte_t     exp_q [router_pkg::NUM_PORTS][$];
  router_pkg::port_vec_t reader_on;
  router_pkg::port_vec_t pending;
  int                    stall [router_pkg::NUM_PORTS];
  int                    run_len [router_pkg::NUM_PORTS];
  int                    last_run [router_pkg::NUM_PORTS];
  int                    lens [NUM_PKTS];
  logic [31:0]           stim_seed;
  logic [31:0]           read_seed;
  int                    busy_waits;
  int                    errors;
  int                    checks;
  int                    cycles;
  int                    limit;

  router_top #(
    .FIFO_DEPTH        (FIFO_DEPTH),
    .SOFT_RESET_CYCLES (SOFT_RESET_CYCLES)
  ) dut0 (
    .clk        (clk),
    .rst        (rst),
    .pkt_valid  (pkt_valid),
    .data_in    (data_in),
    .read_enb   (read_enb),
    .data_out_0 (data_out[0]),
    .data_out_1 (data_out[1]),
    .data_out_2 (data_out[2]),
    .vld_out    (vld_out),
    .err        (err),
    .busy       (busy)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Parity byte is the XOR of the header and every payload byte.
  function automatic router_pkg::byte_t parity_of(input router_pkg::byte_t bytes[$]);
    router_pkg::byte_t p;
    p = '0;
    foreach (bytes[i]) p = p ^ bytes[i];
    return p;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // Hold the byte until a cycle with busy low lets it in.
  task automatic send_byte(input router_pkg::byte_t b, input logic valid);
    data_in = b;
    pkt_valid = valid;
    while (busy) begin
      busy_waits++;
      step();
    end
    step();
  endtask

  task automatic send_packet(input router_pkg::port_sel_t port, input int len,
                             input logic bad_parity);
    router_pkg::byte_t bytes[$];
    router_pkg::byte_t par;
    router_pkg::byte_t hdr;
    hdr = '0;
    hdr[router_pkg::HDR_LEN_MSB:router_pkg::HDR_LEN_LSB] = 6'(len);
    hdr[router_pkg::HDR_PORT_MSB:router_pkg::HDR_PORT_LSB] = port;
    bytes.push_back(hdr);
    for (int i = 0; i < len; i++) begin
      stim_seed = lcg_next(stim_seed);
      bytes.push_back(stim_seed[23:16]);
    end
    par = parity_of(bytes);
    if (bad_parity) par = ~par;
    bytes.push_back(par);
    if (port != router_pkg::INVALID_PORT) begin
      foreach (bytes[i]) exp_q[port].push_back(bytes[i]);
    end
    foreach (bytes[i]) begin
      if (i == 2) busy_waits = 0;
      send_byte(bytes[i], i != bytes.size() - 1);
    end
    data_in = '0;
    pkt_valid = 1'b0;
    while (busy) step();
    if (port != router_pkg::INVALID_PORT) check_val("err", err, bad_parity);
  endtask

  // Last compare lands one cycle after vld_out falls.
  task automatic wait_drained();
    while (vld_out != '0) step();
    repeat (2) step();
  endtask

  // Port readers and the comparing process.
  always @(posedge clk) begin
    #1;
    if (rst) begin
      for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
        if (pending[p]) begin
          checks++;
          if (exp_q[p].size() == 0) begin
            errors++;
            $display("port %0d delivered byte %0h with nothing expected", p, data_out[p]);
          end else begin
            if (data_out[p] !== exp_q[p][0]) begin
              errors++;
              $display("error data_out_%0d: got %0h expected %0h", p, data_out[p], exp_q[p][0]);
            end
            exp_q[p].delete(0);
          end
        end
        pending[p] = 1'b0;
        read_enb[p] = 1'b0;
        if (vld_out[p]) begin
          run_len[p]++;
        end else if (run_len[p] != 0) begin
          last_run[p] = run_len[p];
          run_len[p] = 0;
        end
        if (stall[p] > 0) begin
          stall[p]--;
        end else if (reader_on[p] && vld_out[p]) begin
          read_enb[p] = 1'b1;
          pending[p] = 1'b1;
          read_seed = lcg_next(read_seed);
          stall[p] = read_seed[31] ? 0 : 1 + int'(read_seed[25:24]) % 3;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int total;
    total = 0;
    errors = 0;
    checks = 0;
    cycles = 0;
    busy_waits = 0;
    rst = 1'b0;
    pkt_valid = 1'b0;
    data_in = '0;
    read_enb = '0;
    reader_on = '1;
    pending = '0;
    stim_seed = SEED;
    read_seed = ~SEED;
    for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
      stall[p] = 0;
      run_len[p] = 0;
      last_run[p] = 0;
    end
    for (int i = 0; i < NUM_PKTS; i++) begin
      stim_seed = lcg_next(stim_seed);
      lens[i] = 1 + int'(stim_seed[21:16]) % 40;
    end
    lens[10] = 60;
    lens[13] = 5;
    foreach (lens[i]) total += lens[i] + 2;
    limit = total * 4 + 500;

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;
    check_val("vld_out", vld_out, '0);
    check_val("busy", busy, 1'b0);
    check_val("err", err, 1'b0);

    for (int i = 0; i < 9; i++) send_packet(router_pkg::port_sel_t'(i % 3), lens[i], 1'b0);
    send_packet(2'd1, lens[9], 1'b1);

    // The slow reader cannot keep up with a packet longer than the FIFO.
    send_packet(2'd2, lens[10], 1'b0);
    checks++;
    if (busy_waits == 0) begin
      errors++;
      $display("busy never rose while the long packet was loading");
    end

    wait_drained();
    reader_on = '0;
    send_packet(router_pkg::INVALID_PORT, lens[11], 1'b0);
    repeat (2) step();
    check_val("vld_out", vld_out, '0);
    reader_on = '1;
    send_packet(2'd0, lens[12], 1'b0);

    // Idle timer runs SOFT_RESET_CYCLES cycles and the flush lands one cycle later.
    wait_drained();
    reader_on[1] = 1'b0;
    send_packet(2'd1, lens[13], 1'b0);
    while (vld_out[1]) step();
    step();
    check_val("vld_out_1 high cycles", last_run[1], SOFT_RESET_CYCLES + 1);
    check_val("data_out_1", data_out[1], '0);
    exp_q[1].delete();
    reader_on[1] = 1'b1;
    send_packet(2'd1, lens[14], 1'b0);
    wait_drained();
    for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
      check_val("bytes still expected", exp_q[p].size(), 0);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/router_pkg.sv
rtl/router_fsm.sv
rtl/router_reg.sv
rtl/router_sync.sv
rtl/router_fifo.sv
rtl/router_top.sv
tests/router_properties.sv
tests/router_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module router_tb -f filelist.f -o Vrouter_tb &&
  ./obj_dir/Vrouter_tb > sim.log 2>&1
status=$?
cat sim.log 2>/dev/null
grep -q "SOME TESTS FAILED" sim.log && exit 1
[ "$status" -eq 0 ] && grep -q "ALL TESTS PASSED" sim.log && exit 0
exit 1
